// File: verilog.f
logic/accel_pkg.sv
logic/cmd_decoder.sv
logic/line_packer.sv
logic/line_buffer.sv
logic/buffer_arbiter.sv
logic/gemm_engine.sv
logic/result_fifo.sv
logic/accel_top.sv
verification/tb_accel.sv

// File: run.sh
#!/bin/sh
# build and run the accelerator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_accel -f verilog.f -o tb_accel \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_accel > sim.log 2>&1 || true

grep -q "Everything OK" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

// File: verification/tb_accel.sv
`timescale 1ns/1ps

module tb_accel;

	localparam int BUF_AW     = 8;
	localparam int FIFO_DEPTH = 16;
	localparam int CW         = $clog2(FIFO_DEPTH + 1);
	localparam int MARGIN     = 4;

	logic          okClk, rst, cmd_wr, data_wr, weight_wr, bias_wr, start, res_rd;
	logic [31:0]   cmd_word, cfg, res_data;
	logic [15:0]   word;
	logic          cfg_valid, busy, done, res_valid;
	logic [CW-1:0] res_count;

	logic signed [15:0] d_m [0:255];  // mirror of the loaded data words
	logic signed [15:0] w_m [0:511];
	logic signed [15:0] b_m [0:63];
	int          exp_q [$];
	int          cur_lines;
	logic [31:0] rng;
	bit          drain_en;
	int          popped_cnt, done_cnt, run_total;
	int          errors, checks, tests_passed, tests_failed;
	int          cycles, cycle_limit;

	accel_top #(
		.BUF_AW     (BUF_AW),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uut (
		.okClk(okClk), .i_rst(rst), .i_cmd_wr(cmd_wr), .i_cmd_word(cmd_word),
		.i_data_wr(data_wr), .i_weight_wr(weight_wr), .i_bias_wr(bias_wr), .i_word(word),
		.i_start(start), .i_res_rd(res_rd), .o_cfg(cfg), .o_cfg_valid(cfg_valid),
		.o_busy(busy), .o_done(done), .o_res_valid(res_valid), .o_res_data(res_data),
		.o_res_count(res_count)
	);

	always #5 okClk = ~okClk;

	always @(posedge okClk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	// host pops whenever a result is there and draining is on
	always @(posedge okClk) begin
		#1;
		res_rd = drain_en && res_valid && !rst;
	end

	// compare process samples at the falling edge where outputs are stable
	always @(negedge okClk) begin
		int exp_v;
		if (!rst && done) begin
			check("busy low with done", 32'(busy), 32'd0);
			check("results out at done", popped_cnt + int'(res_count), run_total);
			done_cnt++;
		end
		if (!rst && res_rd && res_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("a result was popped at time %0t but none was expected", $time);
			end else begin
				exp_v = exp_q.pop_front();
				check("result", res_data, exp_v);
			end
			popped_cnt++;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [15:0] rand_word();
		rng = xorshift(rng);
		return rng[15:0];
	endfunction

	// lane-wise signed products summed over all lines plus the sign-extended bias with 32-bit wrap
	function automatic int ref_result(input int o);
		int acc;
		int d;
		int w;
		int l;
		int k;
		acc = b_m[o];
		for (l = 0; l < cur_lines; l++) begin
			for (k = 0; k < 4; k++) begin
				d   = d_m[l*4 + k];
				w   = w_m[(o*cur_lines + l)*4 + k];
				acc = acc + d * w;
			end
		end
		return acc;
	endfunction

	function automatic int run_cost(input int lines, input int ch);
		return ch*(2*lines + 8) + 4*lines + 4*ch*lines + ch + 40;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] time %0t: %s is %0d, expected %0d", $time, what,
				$signed(got), $signed(exp));
		end
	endtask

	task automatic tick();
		@(posedge okClk);
		#1;
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		repeat (10) tick();
		rst = 1'b0;
		exp_q.delete();
	endtask

	task automatic send_cfg(input int lines, input int ch);
		cmd_wr   = 1'b1;
		cmd_word = {16'(ch), 16'(lines)};
		tick();
		cmd_word = {rand_word(), rand_word()}; // trailer word with unused contents
		tick();
		cmd_wr   = 1'b0;
	endtask

	task automatic put_word(input int kind, input logic [15:0] w);
		word      = w;
		data_wr   = (kind == 0);
		weight_wr = (kind == 1);
		bias_wr   = (kind == 2);
		tick();
		data_wr   = 1'b0;
		weight_wr = 1'b0;
		bias_wr   = 1'b0;
	endtask

	// fills the mirrors and streams them to the packer before queueing the expected results
	task automatic load_vectors(input int lines, input int ch, input bit zero_bias);
		int k;
		cur_lines = lines;
		send_cfg(lines, ch);
		for (k = 0; k < lines*4; k++) begin
			d_m[k] = rand_word();
			put_word(0, d_m[k]);
		end
		for (k = 0; k < ch*lines*4; k++) begin
			w_m[k] = rand_word();
			put_word(1, w_m[k]);
		end
		for (k = 0; k < ch; k++) begin
			b_m[k] = zero_bias ? 16'sd0 : rand_word();
			put_word(2, b_m[k]);
		end
		repeat (2) tick(); // last packer write lands
		for (k = 0; k < ch; k++) exp_q.push_back(ref_result(k));
	endtask

	task automatic start_run(input int ch);
		popped_cnt = 0;
		done_cnt   = 0;
		run_total  = ch;
		start      = 1'b1;
		tick();
		start      = 1'b0;
		check("busy one cycle after start", 32'(busy), 32'd1);
	endtask

	task automatic wait_run_end();
		while (popped_cnt < run_total || done_cnt == 0) tick();
		tick();
		check("done pulses", done_cnt, 1);
		check("results popped", popped_cnt, run_total);
		check("busy after run", 32'(busy), 32'd0);
	endtask

	task automatic end_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail", name);
		end
	endtask

	initial begin
		int e;
		okClk     = 1'b0;
		rst       = 1'b1;
		cmd_wr    = 1'b0;
		cmd_word  = '0;
		data_wr   = 1'b0;
		weight_wr = 1'b0;
		bias_wr   = 1'b0;
		word      = '0;
		start     = 1'b0;
		res_rd    = 1'b0;
		drain_en  = 1'b1;
		rng = 32'he867cc1d;
		cycle_limit = MARGIN * (run_cost(1, 1) + run_cost(3, 6) + run_cost(2, 20)
			+ 2*run_cost(2, 4) + run_cost(3, 5) + 8*10 + 60) + 200;
		reset_dut();

		e = errors;
		check("cfg valid after reset", 32'(cfg_valid), 32'd0);
		send_cfg(3, 6);
		check("cfg valid", 32'(cfg_valid), 32'd1);
		check("cfg fields", cfg, {16'd6, 16'd3});
		end_test("cfg readback", e);

		e = errors;
		reset_dut();
		load_vectors(1, 1, 1'b1);
		start_run(1);
		wait_run_end();
		end_test("single dot product", e);

		e = errors;
		reset_dut();
		load_vectors(3, 6, 1'b0);
		start_run(6);
		wait_run_end();
		end_test("multi channel", e);

		// back-pressure with more channels than FIFO slots
		e = errors;
		reset_dut();
		drain_en = 1'b0;
		load_vectors(2, 20, 1'b0);
		start_run(20);
		while (res_count != CW'(FIFO_DEPTH)) tick();
		repeat (40) tick();
		check("count while stalled", res_count, FIFO_DEPTH);
		check("done while stalled", done_cnt, 0);
		check("busy while stalled", 32'(busy), 32'd1);
		drain_en = 1'b1;
		wait_run_end();
		end_test("back-pressure", e);

		e = errors;
		reset_dut();
		load_vectors(2, 4, 1'b0);
		start_run(4);
		repeat (3) tick();
		start = 1'b1; // ignored by a busy engine
		tick();
		start = 1'b0;
		wait_run_end();
		repeat (10) tick();
		check("no second run", 32'(busy), 32'd0);
		check("fifo empty after run", 32'(res_valid), 32'd0);
		check("done pulses in total", done_cnt, 1);
		end_test("start while busy", e);

		e = errors;
		reset_dut();
		drain_en = 1'b0;
		load_vectors(3, 5, 1'b0);
		start_run(5);
		while (res_count == 0) tick();
		rst = 1'b1;
		tick();
		check("busy after mid-run reset", 32'(busy), 32'd0);
		check("res valid after mid-run reset", 32'(res_valid), 32'd0);
		reset_dut();
		drain_en = 1'b1;
		load_vectors(2, 4, 1'b0);
		start_run(4);
		wait_run_end();
		end_test("reset mid-run", e);

		$display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: logic/accel_top.sv
`timescale 1ns/1ps

module accel_top
	import accel_pkg::*;
#(
	parameter int BUF_AW     = accel_pkg::BUF_AW,
	parameter int FIFO_DEPTH = accel_pkg::FIFO_DEPTH
)(
	input  logic                            okClk,
	input  logic                            i_rst,
	input  logic                            i_cmd_wr,
	input  logic [31:0]                     i_cmd_word,
	input  logic                            i_data_wr,
	input  logic                            i_weight_wr,
	input  logic                            i_bias_wr,
	input  word_t                           i_word,
	input  logic                            i_start,
	input  logic                            i_res_rd,
	output cfg_t                            o_cfg,
	output logic                            o_cfg_valid,
	output logic                            o_busy,
	output logic                            o_done,
	output logic                            o_res_valid,
	output acc_t                            o_res_data,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] o_res_count
);

	logic     wr_req, rd_req, rd_grant, rd_valid;
	buf_req_t wr, rd;
	line_t    rd_line;
	logic     push, fifo_full;
	acc_t     result;

	cmd_decoder u_cmd_decoder (
		.okClk(okClk), .i_rst(i_rst), .i_cmd_wr(i_cmd_wr), .i_cmd_word(i_cmd_word),
		.o_cfg(o_cfg), .o_cfg_valid(o_cfg_valid)
	);

	line_packer #(.BUF_AW(BUF_AW)) u_line_packer (
		.okClk(okClk), .i_rst(i_rst), .i_data_wr(i_data_wr), .i_weight_wr(i_weight_wr),
		.i_bias_wr(i_bias_wr), .i_word(i_word), .o_wr_req(wr_req), .o_wr(wr)
	);

	// packer writes always win the shared port
	buffer_arbiter #(.BUF_AW(BUF_AW)) u_buffer_arbiter (
		.okClk(okClk), .i_rst(i_rst), .i_wr_req(wr_req), .i_wr(wr), .i_rd_req(rd_req),
		.i_rd(rd), .o_rd_grant(rd_grant), .o_rd_valid(rd_valid), .o_rd_line(rd_line)
	);

	gemm_engine #(.BUF_AW(BUF_AW)) u_gemm_engine (
		.okClk(okClk), .i_rst(i_rst), .i_start(i_start), .i_cfg(o_cfg),
		.i_cfg_valid(o_cfg_valid), .o_rd_req(rd_req), .o_rd(rd), .i_rd_grant(rd_grant),
		.i_rd_valid(rd_valid), .i_rd_line(rd_line), .o_push(push), .o_result(result),
		.i_fifo_full(fifo_full), .o_busy(o_busy), .o_done(o_done)
	);

	result_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_result_fifo (
		.okClk(okClk), .i_rst(i_rst), .i_push(push), .i_data(result), .i_pop(i_res_rd),
		.o_data(o_res_data), .o_valid(o_res_valid), .o_full(fifo_full), .o_count(o_res_count)
	);

endmodule

// File: logic/result_fifo.sv
`timescale 1ns/1ps

module result_fifo
	import accel_pkg::*;
#(
	parameter int FIFO_DEPTH = accel_pkg::FIFO_DEPTH
)(
	input  logic                           okClk,
	input  logic                           i_rst,
	input  logic                           i_push,
	input  acc_t                           i_data,
	input  logic                           i_pop,
	output acc_t                           o_data,
	output logic                           o_valid,
	output logic                           o_full,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] o_count
);

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);
	localparam logic [PW-1:0] LAST_SLOT = PW'(FIFO_DEPTH - 1);
	localparam logic [CW-1:0] FULL_CNT  = CW'(FIFO_DEPTH);

	acc_t          mem [0:FIFO_DEPTH-1];
	logic [PW-1:0] wr_ptr, rd_ptr;
	logic          do_push, do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && o_valid;
	assign o_valid = (o_count != '0);
	assign o_full  = (o_count == FULL_CNT);
	assign o_data  = mem[rd_ptr]; // head shows without a pop

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (do_push) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (do_push) mem[wr_ptr] <= i_data;
	end

	// engine stalls on full, host only pops a valid head
	a_no_overflow: assert property (@(posedge okClk) disable iff (i_rst)
		!(i_push && o_full) && !(i_pop && !o_valid));

endmodule

// File: logic/gemm_engine.sv
`timescale 1ns/1ps

module gemm_engine
	import accel_pkg::*;
#(
	parameter int BUF_AW = accel_pkg::BUF_AW
)(
	input  logic     okClk,
	input  logic     i_rst,
	input  logic     i_start,
	input  cfg_t     i_cfg,
	input  logic     i_cfg_valid,
	output logic     o_rd_req,
	output buf_req_t o_rd,
	input  logic     i_rd_grant,
	input  logic     i_rd_valid,
	input  line_t    i_rd_line,
	output logic     o_push,
	output acc_t     o_result,
	input  logic     i_fifo_full,
	output logic     o_busy,
	output logic     o_done
);

	localparam logic [BUF_AW-1:0] D_BASE = '0;
	localparam logic [BUF_AW-1:0] W_BASE = BUF_AW'(1) << (BUF_AW - 2);
	localparam logic [BUF_AW-1:0] B_BASE = BUF_AW'(3) << (BUF_AW - 2);

	engine_state_t     state;
	cfg_t              cfg_q;       // held for the whole run
	logic [15:0]       ch_cnt, line_cnt;
	logic [BUF_AW-1:0] w_addr, rd_addr;
	line_t             data_q;
	acc_t              acc, lane_sum, bias_ext;
	logic              start_ok, last_line, last_ch;

	assign start_ok  = (state == IDLE) && i_start && i_cfg_valid;
	assign last_line = (line_cnt == cfg_q.i_lines - 16'd1);
	assign last_ch   = (ch_cnt == cfg_q.o_channels - 16'd1);
	assign bias_ext  = acc_t'(word_t'(i_rd_line[WORD_W-1:0])); // lane 0 only

	// four signed lane products, weight line straight off the buffer
	always_comb begin
		word_t d_w;
		word_t w_w;
		lane_sum = '0;
		for (int i = 0; i < LANES; i++) begin
			d_w      = data_q[i*WORD_W +: WORD_W];
			w_w      = i_rd_line[i*WORD_W +: WORD_W];
			lane_sum = lane_sum + acc_t'(d_w) * acc_t'(w_w);
		end
	end

	always_comb begin
		case (state)
			RD_WEIGHT: rd_addr = w_addr;
			RD_BIAS:   rd_addr = B_BASE + BUF_AW'(ch_cnt);
			default:   rd_addr = D_BASE + BUF_AW'(line_cnt);
		endcase
	end

	assign o_rd_req = (state == RD_DATA) || (state == RD_WEIGHT) || (state == RD_BIAS);
	assign o_rd     = '{wr: 1'b0, addr: buf_addr_t'(rd_addr), line: '0};
	// first PUSH cycle folds in the bias, push from the next one on
	assign o_push   = (state == PUSH) && !i_rd_valid && !i_fifo_full;
	assign o_result = acc;
	assign o_busy   = (state != IDLE) && (state != DONE);
	assign o_done   = (state == DONE);

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			state    <= IDLE;
			ch_cnt   <= '0;
			line_cnt <= '0;
			w_addr   <= W_BASE;
		end else begin
			case (state)
				IDLE: begin
					if (start_ok) begin
						state    <= RD_DATA;
						ch_cnt   <= '0;
						line_cnt <= '0;
						w_addr   <= W_BASE;
					end
				end
				RD_DATA: begin
					if (i_rd_grant) state <= RD_WEIGHT;
				end
				RD_WEIGHT: begin
					if (i_rd_grant) state <= MAC;
				end
				MAC: begin
					w_addr <= w_addr + 1'b1; // weights run on across channels
					if (last_line) begin
						line_cnt <= '0;
						state    <= RD_BIAS;
					end else begin
						line_cnt <= line_cnt + 16'd1;
						state    <= RD_DATA;
					end
				end
				RD_BIAS: begin
					if (i_rd_grant) state <= PUSH;
				end
				PUSH: begin
					if (o_push) begin
						if (last_ch) begin
							state <= DONE;
						end else begin
							ch_cnt <= ch_cnt + 16'd1;
							state  <= RD_DATA;
						end
					end
				end
				default: state <= IDLE; // DONE lasts one cycle
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (start_ok) begin
			cfg_q <= i_cfg;
			acc   <= '0;
		end
		if (state == RD_WEIGHT && i_rd_valid) begin
			data_q <= i_rd_line; // data line returns while weight read waits
		end
		if (state == MAC) begin
			acc <= acc + lane_sum;
		end else if (state == PUSH) begin
			if (i_rd_valid) begin
				acc <= acc + bias_ext;
			end else if (o_push) begin
				acc <= '0;
			end
		end
	end

	// weight line must arrive exactly in MAC, the arbiter keeps that promise
	a_mac_data: assert property (@(posedge okClk) disable iff (i_rst)
		(state == MAC) |-> i_rd_valid);

	a_start_ok: assert property (@(posedge okClk) disable iff (i_rst)
		i_start |-> (state == IDLE) && i_cfg_valid)
		else $warning("start ignored, engine busy or no valid config");

endmodule

// File: logic/buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter
	import accel_pkg::*;
#(
	parameter int BUF_AW = accel_pkg::BUF_AW
)(
	input  logic     okClk,
	input  logic     i_rst,
	input  logic     i_wr_req,   // packer write has fixed priority
	input  buf_req_t i_wr,
	input  logic     i_rd_req,   // engine read held until granted
	input  buf_req_t i_rd,
	output logic     o_rd_grant,
	output logic     o_rd_valid,
	output line_t    o_rd_line
);

	buf_req_t port_req;
	logic     port_en;

	assign o_rd_grant = i_rd_req && !i_wr_req;
	assign port_en    = i_wr_req || i_rd_req;

	always_comb begin
		port_req    = i_wr_req ? i_wr : i_rd;
		port_req.wr = i_wr_req; // engine side never writes
	end

	// registered read data lands one cycle after the grant
	always_ff @(posedge okClk) begin
		if (i_rst) begin
			o_rd_valid <= 1'b0;
		end else begin
			o_rd_valid <= o_rd_grant;
		end
	end

	line_buffer #(
		.BUF_AW   (BUF_AW)
	) u_line_buffer (
		.okClk    (okClk),
		.i_req    (port_req),
		.i_en     (port_en),
		.o_rd_line(o_rd_line)
	);

	// a waiting read keeps its request and address until the grant comes
	a_rd_held: assert property (@(posedge okClk) disable iff (i_rst)
		i_rd_req && !o_rd_grant |=> i_rd_req && $stable(i_rd.addr));

endmodule

// File: logic/line_buffer.sv
`timescale 1ns/1ps

module line_buffer
	import accel_pkg::*;
#(
	parameter int BUF_AW = accel_pkg::BUF_AW
)(
	input  logic     okClk,
	input  buf_req_t i_req,
	input  logic     i_en,
	output line_t    o_rd_line
);

	line_t             mem [0:2**BUF_AW-1];
	logic [BUF_AW-1:0] addr;

	assign addr = BUF_AW'(i_req.addr);

	// one port, a write cycle leaves o_rd_line unchanged
	always_ff @(posedge okClk) begin
		if (i_en) begin
			if (i_req.wr) begin
				mem[addr] <= i_req.line;
			end else begin
				o_rd_line <= mem[addr];
			end
		end
	end

endmodule

// File: logic/line_packer.sv
`timescale 1ns/1ps

module line_packer
	import accel_pkg::*;
#(
	parameter int BUF_AW = accel_pkg::BUF_AW
)(
	input  logic     okClk,
	input  logic     i_rst,
	input  logic     i_data_wr,
	input  logic     i_weight_wr,
	input  logic     i_bias_wr,
	input  word_t    i_word,
	output logic     o_wr_req,
	output buf_req_t o_wr
);

	localparam int LW = $clog2(LANES);
	localparam logic [LW-1:0]     LAST_LANE = LW'(LANES - 1);
	localparam logic [BUF_AW-1:0] D_BASE    = '0;
	localparam logic [BUF_AW-1:0] W_BASE    = BUF_AW'(1) << (BUF_AW - 2);
	localparam logic [BUF_AW-1:0] B_BASE    = BUF_AW'(3) << (BUF_AW - 2);

	line_t             data_line, weight_line;
	line_t             data_next, weight_next;
	logic [LW-1:0]     data_lane, weight_lane;
	logic [BUF_AW-1:0] data_addr, weight_addr, bias_addr;

	// new word enters at the top, first word ends up in lane 0
	assign data_next   = {i_word, data_line[$bits(line_t)-1:WORD_W]};
	assign weight_next = {i_word, weight_line[$bits(line_t)-1:WORD_W]};

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			data_lane   <= '0;
			weight_lane <= '0;
			data_addr   <= D_BASE;
			weight_addr <= W_BASE;
			bias_addr   <= B_BASE;
			o_wr_req    <= 1'b0;
		end else begin
			o_wr_req <= 1'b0;
			if (i_data_wr) begin
				data_lane <= (data_lane == LAST_LANE) ? '0 : data_lane + 1'b1;
				if (data_lane == LAST_LANE) begin
					o_wr_req  <= 1'b1;
					data_addr <= data_addr + 1'b1;
				end
			end
			if (i_weight_wr) begin
				weight_lane <= (weight_lane == LAST_LANE) ? '0 : weight_lane + 1'b1;
				if (weight_lane == LAST_LANE) begin
					o_wr_req    <= 1'b1;
					weight_addr <= weight_addr + 1'b1;
				end
			end
			if (i_bias_wr) begin
				o_wr_req  <= 1'b1; // every bias word is its own line
				bias_addr <= bias_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (i_data_wr) begin
			data_line <= data_next;
			if (data_lane == LAST_LANE) begin
				o_wr <= '{wr: 1'b1, addr: buf_addr_t'(data_addr), line: data_next};
			end
		end
		if (i_weight_wr) begin
			weight_line <= weight_next;
			if (weight_lane == LAST_LANE) begin
				o_wr <= '{wr: 1'b1, addr: buf_addr_t'(weight_addr), line: weight_next};
			end
		end
		if (i_bias_wr) begin
			o_wr <= '{wr: 1'b1, addr: buf_addr_t'(bias_addr), line: line_t'($unsigned(i_word))};
		end
	end

	// strobes share o_wr, two at once would lose a line
	a_one_strobe: assert property (@(posedge okClk) disable iff (i_rst)
		$onehot0({i_data_wr, i_weight_wr, i_bias_wr}));

endmodule

// File: logic/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder
	import accel_pkg::*;
(
	input  logic        okClk,
	input  logic        i_rst,
	input  logic        i_cmd_wr,
	input  logic [31:0] i_cmd_word,
	output cfg_t        o_cfg,
	output logic        o_cfg_valid
);

	logic word_sel; // 0: config word next, 1: trailer next

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			word_sel    <= 1'b0;
			o_cfg_valid <= 1'b0;
		end else if (i_cmd_wr) begin
			if (!word_sel) begin
				word_sel    <= 1'b1;
				o_cfg_valid <= 1'b0; // new command started, old config gone
			end else begin
				word_sel    <= 1'b0;
				o_cfg_valid <= 1'b1;
			end
		end
	end

	// fields only come from word 0, word 1 is just a terminator
	always_ff @(posedge okClk) begin
		if (i_cmd_wr && !word_sel) begin
			o_cfg <= cfg_t'(i_cmd_word);
		end
	end

	// a zero count would hang the engine in its read loop
	property p_cfg_nonzero;
		@(posedge okClk) disable iff (i_rst)
		o_cfg_valid |-> (o_cfg.i_lines != '0) && (o_cfg.o_channels != '0);
	endproperty

	a_cfg_nonzero: assert property (p_cfg_nonzero);

endmodule

// File: logic/accel_pkg.sv
package accel_pkg;

	localparam int LANES      = 4;   // 16-bit lanes per buffer line
	localparam int WORD_W     = 16;
	localparam int ACC_W      = 32;
	localparam int BUF_AW     = 8;   // default only, modules get theirs from the top
	localparam int FIFO_DEPTH = 16;

	typedef logic signed [WORD_W-1:0]       word_t;
	typedef logic        [LANES*WORD_W-1:0] line_t;  // lane 0 in the low bits
	typedef logic signed [ACC_W-1:0]        acc_t;

	// request address field is sized by the default width
	// module BUF_AW must not exceed it
	typedef logic [BUF_AW-1:0] buf_addr_t;

	// word 0 of a command maps straight onto this struct
	typedef struct packed {
		logic [15:0] o_channels; // high half
		logic [15:0] i_lines;    // low half, lines per dot product
	} cfg_t;

	typedef struct packed {
		logic      wr;
		buf_addr_t addr;
		line_t     line;
	} buf_req_t;

	// buffer regions, one quarter each, from a module's BUF_AW:
	//   data    base 0
	//   weights base 1 << (BUF_AW-2), spans quarters 1 and 2
	//   bias    base 3 << (BUF_AW-2), one bias word per line in lane 0
	// weights of channel o start at weight base + o*i_lines

	typedef enum logic [2:0] {
		IDLE,
		RD_DATA,
		RD_WEIGHT,
		MAC,
		RD_BIAS,
		PUSH,
		DONE
	} engine_state_t;

endpackage
